// ==== source/sensor_pkg.sv ====
package sensor_pkg;

	//==============================
	// widths with a meaning
	//==============================
	typedef logic [7:0]  reg_byte_t; // register address or data byte
	typedef logic [15:0] uart_rx_t;  // command code in the high byte
	typedef logic [31:0] uart_tx_t;  // one transmit frame
	typedef logic [23:0] payload_t;  // sample payload
	typedef logic [11:0] touch_t;    // one bit per electrode

	// which producer a FIFO entry came from
	typedef enum logic {
		TAG_TOUCH = 1'b0,
		TAG_ECG   = 1'b1
	} sample_tag_t;

	//==============================
	// uart codes
	//==============================
	// frame headers, first byte on the wire
	localparam reg_byte_t HDR_TOUCH = 8'hBB;
	localparam reg_byte_t HDR_ECG   = 8'hAA;

	// command codes from the host
	localparam reg_byte_t CMD_RUN  = 8'h52; // 'R'
	localparam reg_byte_t CMD_STOP = 8'h53; // 'S'

endpackage

// ==== source/sensor_chip_pkg.sv ====
package sensor_chip_pkg;

	//==============================
	// mpr121 registers
	//==============================
	localparam sensor_pkg::reg_byte_t MPR_TOUCH_STATUS_0 = 8'h00; // ele0..7
	localparam sensor_pkg::reg_byte_t MPR_TOUCH_STATUS_1 = 8'h01; // ele8..11 in low nibble

	// electrode config, also switches run and stop mode
	localparam sensor_pkg::reg_byte_t MPR_ELE_CONFIG = 8'h5E;
	localparam sensor_pkg::reg_byte_t MPR_ELE_RUN    = 8'h8F; // all 12 electrodes on
	localparam sensor_pkg::reg_byte_t MPR_ELE_STOP   = 8'h00;

	//==============================
	// ads1292 control codes
	//==============================
	typedef enum logic [2:0] {
		RDATAC = 3'b100, // enter read data continuous
		SDATAC = 3'b101, // leave read data continuous
		DUMMY  = 3'b111  // no operation
	} ads_ctrl_t;

endpackage

// ==== source/sample_if.sv ====
`timescale 1ns/1ps

// one tagged sample stream, valid/ready handshake
interface sample_if;

	logic                    valid;
	logic                    ready;
	sensor_pkg::sample_tag_t tag;
	sensor_pkg::payload_t    payload;

	// tag and payload hold still while valid waits for ready
	modport source (output valid, output tag, output payload, input ready);
	modport sink (input valid, input tag, input payload, output ready);

endinterface

// ==== source/run_control.sv ====
`timescale 1ns/1ps

module run_control (
	input  logic                 i_CLK,
	input  logic                 i_RST,
	input  sensor_pkg::uart_rx_t i_uart_rx_data,
	input  logic                 i_uart_rx_valid,
	input  logic                 i_mpr_init_set,
	input  logic                 i_ads_init_set,
	input  logic                 i_touch_running,
	input  logic                 i_ecg_running,
	output logic                 o_run_req,
	output logic                 o_run_set,
	output logic                 o_core_busy
);

	typedef enum logic [1:0] {
		ST_WAIT_INIT,
		ST_STANDBY,
		ST_READING
	} run_state_t;

	run_state_t r_state;
	logic       w_all_running;
	logic       w_cmd_ok; // command word arrives after init

	assign w_all_running = i_touch_running && i_ecg_running;
	assign w_cmd_ok = i_uart_rx_valid && (r_state != ST_WAIT_INIT);
	assign o_core_busy = (r_state == ST_READING);

	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			r_state <= ST_WAIT_INIT;
			o_run_req <= 1'b0;
			o_run_set <= 1'b0;
		end else begin
			o_run_set <= w_all_running;
			if (w_cmd_ok) begin
				if (i_uart_rx_data[15:8] == sensor_pkg::CMD_RUN) begin
					o_run_req <= 1'b1;
				end else if (i_uart_rx_data[15:8] == sensor_pkg::CMD_STOP) begin
					o_run_req <= 1'b0;
				end // other codes ignored
			end
			case (r_state)
				ST_WAIT_INIT: begin
					if (i_mpr_init_set && i_ads_init_set) begin
						r_state <= ST_STANDBY;
					end
				end
				ST_STANDBY: begin
					if (o_run_req && w_all_running) begin
						r_state <= ST_READING;
					end
				end
				ST_READING: begin
					if (!(o_run_req && w_all_running)) begin
						r_state <= ST_STANDBY;
					end
				end
				default: r_state <= ST_WAIT_INIT;
			endcase
		end
	end

	// busy only while both producers still report running
	assert property (@(posedge i_CLK) disable iff (i_RST) o_core_busy |-> o_run_set)
		else $error("run_control: core busy without run set");

endmodule

// ==== source/touch_poller.sv ====
`timescale 1ns/1ps

module touch_poller (
	input  logic                  i_CLK,
	input  logic                  i_RST,
	input  logic                  i_run_req,
	input  sensor_pkg::reg_byte_t i_mpr_data,
	input  logic                  i_mpr_busy,
	input  logic                  i_mpr_fail,
	output sensor_pkg::reg_byte_t o_mpr_addr,
	output sensor_pkg::reg_byte_t o_mpr_wdata,
	output logic                  o_mpr_write_en,
	output logic                  o_mpr_read_en,
	output logic                  o_running,
	output logic                  o_mpr_error,
	sample_if.source              touch_s
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_ELE_RUN,  // write electrode config, run value
		ST_READ_0,   // read status 0
		ST_READ_1,   // read status 1
		ST_OFFER,    // sample waits for the fifo
		ST_ELE_STOP  // write electrode config, stop value
	} touch_state_t;

	touch_state_t       r_state;
	logic               r_issued; // enable already pulsed for this access
	logic               w_done;
	sensor_pkg::touch_t r_mask;

	// busy is only looked at once the enable pulse is gone
	assign w_done = r_issued && !o_mpr_write_en && !o_mpr_read_en && !i_mpr_busy;

	assign touch_s.tag = sensor_pkg::TAG_TOUCH;
	assign touch_s.payload = {12'h000, r_mask};

	//==============================
	// access and poll sequence
	//==============================
	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			r_state <= ST_IDLE;
			r_issued <= 1'b0;
			o_mpr_addr <= '0;
			o_mpr_wdata <= '0;
			o_mpr_write_en <= 1'b0;
			o_mpr_read_en <= 1'b0;
			o_running <= 1'b0;
			o_mpr_error <= 1'b0;
			touch_s.valid <= 1'b0;
		end else begin
			o_mpr_write_en <= 1'b0;
			o_mpr_read_en <= 1'b0;
			case (r_state)
				ST_IDLE: begin
					if (i_run_req && !o_mpr_error) begin // error blocks until reset
						o_mpr_addr <= sensor_chip_pkg::MPR_ELE_CONFIG;
						o_mpr_wdata <= sensor_chip_pkg::MPR_ELE_RUN;
						r_state <= ST_ELE_RUN;
					end
				end
				ST_ELE_RUN, ST_READ_0, ST_READ_1, ST_ELE_STOP: begin
					if (!r_issued) begin
						o_mpr_write_en <= (r_state == ST_ELE_RUN) || (r_state == ST_ELE_STOP);
						o_mpr_read_en <= (r_state == ST_READ_0) || (r_state == ST_READ_1);
						r_issued <= 1'b1;
					end else if (w_done) begin
						r_issued <= 1'b0;
						if (i_mpr_fail) begin
							o_mpr_error <= 1'b1;
							o_running <= 1'b0;
							r_state <= ST_IDLE;
						end else if (r_state == ST_READ_1) begin
							touch_s.valid <= 1'b1; // pair complete
							r_state <= ST_OFFER;
						end else if (r_state == ST_ELE_STOP) begin
							o_running <= 1'b0;
							r_state <= ST_IDLE;
						end else if (!i_run_req) begin
							o_mpr_addr <= sensor_chip_pkg::MPR_ELE_CONFIG;
							o_mpr_wdata <= sensor_chip_pkg::MPR_ELE_STOP;
							r_state <= ST_ELE_STOP;
						end else if (r_state == ST_ELE_RUN) begin
							o_running <= 1'b1;
							o_mpr_addr <= sensor_chip_pkg::MPR_TOUCH_STATUS_0;
							r_state <= ST_READ_0;
						end else begin
							o_mpr_addr <= sensor_chip_pkg::MPR_TOUCH_STATUS_1;
							r_state <= ST_READ_1;
						end
					end
				end
				ST_OFFER: begin
					if (touch_s.ready) begin
						touch_s.valid <= 1'b0;
						if (i_run_req) begin
							o_mpr_addr <= sensor_chip_pkg::MPR_TOUCH_STATUS_0;
							r_state <= ST_READ_0;
						end else begin
							o_mpr_addr <= sensor_chip_pkg::MPR_ELE_CONFIG;
							o_mpr_wdata <= sensor_chip_pkg::MPR_ELE_STOP;
							r_state <= ST_ELE_STOP;
						end
					end
				end
				default: r_state <= ST_IDLE;
			endcase
		end
	end

	// touch mask, low byte from status 0, high nibble from status 1
	always_ff @(posedge i_CLK) begin
		if (w_done && !i_mpr_fail && (r_state == ST_READ_0)) begin
			r_mask[7:0] <= i_mpr_data;
		end
		if (w_done && !i_mpr_fail && (r_state == ST_READ_1)) begin
			r_mask[11:8] <= i_mpr_data[3:0];
		end
	end

	assert property (@(posedge i_CLK) disable iff (i_RST) !(o_mpr_write_en && o_mpr_read_en))
		else $error("touch_poller: write and read enable high together");

endmodule

// ==== source/ecg_capture.sv ====
`timescale 1ns/1ps

module ecg_capture (
	input  logic                       i_CLK,
	input  logic                       i_RST,
	input  logic                       i_run_req,
	input  logic [71:0]                i_ads_data,
	input  logic                       i_ads_data_ready,
	output sensor_chip_pkg::ads_ctrl_t o_ads_ctrl,
	output logic                       o_running,
	sample_if.source                   ecg_s
);

	typedef enum logic {
		ST_IDLE,
		ST_RUN   // ads in read data continuous mode
	} ecg_state_t;

	ecg_state_t           r_state;
	logic                 w_take; // new sample latched this cycle
	sensor_pkg::payload_t r_sample;

	// ads cannot be stalled, a sample arriving while one is held is lost
	assign w_take = (r_state == ST_RUN) && i_ads_data_ready && (!ecg_s.valid || ecg_s.ready);

	assign o_running = (r_state == ST_RUN);
	assign ecg_s.tag = sensor_pkg::TAG_ECG;
	assign ecg_s.payload = r_sample;

	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			r_state <= ST_IDLE;
			o_ads_ctrl <= sensor_chip_pkg::DUMMY;
			ecg_s.valid <= 1'b0;
		end else begin
			o_ads_ctrl <= sensor_chip_pkg::DUMMY; // control codes last one cycle
			case (r_state)
				ST_IDLE: begin
					if (i_run_req) begin
						o_ads_ctrl <= sensor_chip_pkg::RDATAC;
						r_state <= ST_RUN;
					end
				end
				ST_RUN: begin
					if (!i_run_req) begin
						o_ads_ctrl <= sensor_chip_pkg::SDATAC;
						r_state <= ST_IDLE;
					end
				end
				default: r_state <= ST_IDLE;
			endcase

			if (w_take) begin
				ecg_s.valid <= 1'b1;
			end else if (ecg_s.ready) begin
				ecg_s.valid <= 1'b0;
			end
		end
	end

	// channel 2 sits in the low 24 bits of the frame
	always_ff @(posedge i_CLK) begin
		if (w_take) begin
			r_sample <= i_ads_data[23:0];
		end
	end

	// a stalled sample keeps its value until the fifo takes it
	assert property (@(posedge i_CLK) disable iff (i_RST)
		ecg_s.valid && !ecg_s.ready |=> ecg_s.valid && $stable(ecg_s.payload))
		else $error("ecg_capture: held sample changed or dropped");

endmodule

// ==== source/frame_fifo.sv ====
`timescale 1ns/1ps

module frame_fifo #(
	parameter int FIFO_DEPTH = 8 // power of two
) (
	input  logic     i_CLK,
	input  logic     i_RST,
	sample_if.sink   touch_s,
	sample_if.sink   ecg_s,
	sample_if.source fifo_s
);

	localparam int ADDR_W = $clog2(FIFO_DEPTH);
	localparam logic [ADDR_W:0] FULL_CNT = FIFO_DEPTH[ADDR_W:0];

	sensor_pkg::sample_tag_t r_tag_mem [FIFO_DEPTH];
	sensor_pkg::payload_t    r_data_mem [FIFO_DEPTH];
	logic [ADDR_W-1:0]       r_wr_ptr;
	logic [ADDR_W-1:0]       r_rd_ptr;
	logic [ADDR_W:0]         r_count;
	logic                    w_full;
	logic                    w_push;
	logic                    w_pop;
	sensor_pkg::sample_tag_t w_wr_tag;
	sensor_pkg::payload_t    w_wr_data;

	//==============================
	// write side
	//==============================
	assign w_full = (r_count == FULL_CNT);
	assign ecg_s.ready = !w_full;
	assign touch_s.ready = !w_full && !ecg_s.valid; // touch waits when ecg writes
	assign w_push = (ecg_s.valid || touch_s.valid) && !w_full;
	assign w_wr_tag = ecg_s.valid ? ecg_s.tag : touch_s.tag;
	assign w_wr_data = ecg_s.valid ? ecg_s.payload : touch_s.payload;

	always_ff @(posedge i_CLK) begin
		if (w_push) begin
			r_tag_mem[r_wr_ptr] <= w_wr_tag;
			r_data_mem[r_wr_ptr] <= w_wr_data;
		end
	end

	// read side, head entry shown as soon as count is nonzero
	assign fifo_s.valid = (r_count != '0);
	assign fifo_s.tag = r_tag_mem[r_rd_ptr];
	assign fifo_s.payload = r_data_mem[r_rd_ptr];
	assign w_pop = fifo_s.valid && fifo_s.ready;

	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			r_wr_ptr <= '0;
			r_rd_ptr <= '0;
			r_count <= '0;
		end else begin
			if (w_push) r_wr_ptr <= r_wr_ptr + ADDR_W'(1); // wraps at depth
			if (w_pop) r_rd_ptr <= r_rd_ptr + ADDR_W'(1);
			case ({w_push, w_pop})
				2'b10:   r_count <= r_count + (ADDR_W + 1)'(1);
				2'b01:   r_count <= r_count - (ADDR_W + 1)'(1);
				default: r_count <= r_count;
			endcase
		end
	end

	assert property (@(posedge i_CLK) disable iff (i_RST) r_count <= FULL_CNT)
		else $error("frame_fifo: count above depth");

endmodule

// ==== source/uart_framer.sv ====
`timescale 1ns/1ps

module uart_framer (
	input  logic                 i_CLK,
	input  logic                 i_RST,
	input  logic                 i_uart_tx_ready,
	output sensor_pkg::uart_tx_t o_uart_tx_data,
	output logic                 o_uart_tx_valid,
	sample_if.sink               fifo_s
);

	logic                 w_load; // fifo entry moves into the output register
	sensor_pkg::touch_t   w_mask;
	sensor_pkg::uart_tx_t w_frame;

	// room when empty or when the uart takes the current frame
	assign fifo_s.ready = !o_uart_tx_valid || i_uart_tx_ready;
	assign w_load = fifo_s.valid && fifo_s.ready;
	assign w_mask = fifo_s.payload[11:0];

	always_comb begin
		if (fifo_s.tag == sensor_pkg::TAG_ECG) begin
			w_frame = {sensor_pkg::HDR_ECG, fifo_s.payload};
		end else begin
			w_frame = {sensor_pkg::HDR_TOUCH, 4'h0, w_mask, 8'h00}; // trailing zero byte
		end
	end

	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			o_uart_tx_valid <= 1'b0;
		end else if (w_load) begin
			o_uart_tx_valid <= 1'b1;
		end else if (i_uart_tx_ready) begin
			o_uart_tx_valid <= 1'b0;
		end
	end

	always_ff @(posedge i_CLK) begin
		if (w_load) begin
			o_uart_tx_data <= w_frame;
		end
	end

endmodule

// ==== source/sensor_core.sv ====
`timescale 1ns/1ps

module sensor_core #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                       i_CLK,
	input  logic                       i_RST,
	// uart controller
	output sensor_pkg::uart_tx_t       o_uart_tx_data,
	output logic                       o_uart_tx_valid,
	input  logic                       i_uart_tx_ready,
	input  sensor_pkg::uart_rx_t       i_uart_rx_data,
	input  logic                       i_uart_rx_valid,
	// mpr121 bus controller
	input  sensor_pkg::reg_byte_t      i_mpr_data,
	output sensor_pkg::reg_byte_t      o_mpr_addr,
	output sensor_pkg::reg_byte_t      o_mpr_wdata,
	output logic                       o_mpr_write_en,
	output logic                       o_mpr_read_en,
	input  logic                       i_mpr_init_set,
	input  logic                       i_mpr_busy,
	input  logic                       i_mpr_fail,
	output logic                       o_mpr_error,
	// ads1292 bus controller
	input  logic [71:0]                i_ads_data,
	output sensor_chip_pkg::ads_ctrl_t o_ads_ctrl,
	input  logic                       i_ads_init_set,
	input  logic                       i_ads_data_ready,
	// status
	output logic                       o_run_set,
	output logic                       o_core_busy
);

	logic w_run_req;
	logic w_touch_running;
	logic w_ecg_running;

	sample_if touch_s ();
	sample_if ecg_s ();
	sample_if fifo_s ();

	run_control u_run_control (
		.i_CLK           (i_CLK),
		.i_RST           (i_RST),
		.i_uart_rx_data  (i_uart_rx_data),
		.i_uart_rx_valid (i_uart_rx_valid),
		.i_mpr_init_set  (i_mpr_init_set),
		.i_ads_init_set  (i_ads_init_set),
		.i_touch_running (w_touch_running),
		.i_ecg_running   (w_ecg_running),
		.o_run_req       (w_run_req),
		.o_run_set       (o_run_set),
		.o_core_busy     (o_core_busy)
	);

	touch_poller u_touch_poller (
		.i_CLK          (i_CLK),
		.i_RST          (i_RST),
		.i_run_req      (w_run_req),
		.i_mpr_data     (i_mpr_data),
		.i_mpr_busy     (i_mpr_busy),
		.i_mpr_fail     (i_mpr_fail),
		.o_mpr_addr     (o_mpr_addr),
		.o_mpr_wdata    (o_mpr_wdata),
		.o_mpr_write_en (o_mpr_write_en),
		.o_mpr_read_en  (o_mpr_read_en),
		.o_running      (w_touch_running),
		.o_mpr_error    (o_mpr_error),
		.touch_s        (touch_s.source)
	);

	ecg_capture u_ecg_capture (
		.i_CLK            (i_CLK),
		.i_RST            (i_RST),
		.i_run_req        (w_run_req),
		.i_ads_data       (i_ads_data),
		.i_ads_data_ready (i_ads_data_ready),
		.o_ads_ctrl       (o_ads_ctrl),
		.o_running        (w_ecg_running),
		.ecg_s            (ecg_s.source)
	);

	frame_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_frame_fifo (
		.i_CLK   (i_CLK),
		.i_RST   (i_RST),
		.touch_s (touch_s.sink),
		.ecg_s   (ecg_s.sink),
		.fifo_s  (fifo_s.source)
	);

	uart_framer u_uart_framer (
		.i_CLK           (i_CLK),
		.i_RST           (i_RST),
		.i_uart_tx_ready (i_uart_tx_ready),
		.o_uart_tx_data  (o_uart_tx_data),
		.o_uart_tx_valid (o_uart_tx_valid),
		.fifo_s          (fifo_s.sink)
	);

endmodule

// ==== sim/chip_models.sv ====
`timescale 1ns/1ps

//==============================
// mpr121 bus controller
//==============================
module mpr121_model (
	input  logic                  i_CLK,
	input  logic                  i_RST,
	input  sensor_pkg::reg_byte_t i_addr,
	input  sensor_pkg::reg_byte_t i_wdata,
	input  logic                  i_write_en,
	input  logic                  i_read_en,
	input  sensor_pkg::touch_t    i_mask,      // electrodes currently touched
	input  logic                  i_fail_next, // next access reports a failure
	output sensor_pkg::reg_byte_t o_data,
	output logic                  o_busy,
	output logic                  o_fail
);

	logic [15:0]           write_log [$]; // {address, data} of every write
	sensor_pkg::touch_t    pair_log [$];  // mask handed out by each status 0/1 pair
	sensor_pkg::reg_byte_t r_addr;
	sensor_pkg::reg_byte_t r_status_0;
	logic                  r_read;
	logic                  r_fail_pend;
	int                    r_wait;

	always @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			o_data <= '0;
			o_busy <= 1'b0;
			o_fail <= 1'b0;
			r_addr <= '0;
			r_read <= 1'b0;
			r_fail_pend <= 1'b0;
			r_wait <= 0;
		end else if (i_write_en || i_read_en) begin
			o_busy <= 1'b1;
			o_fail <= 1'b0;
			r_addr <= i_addr;
			r_read <= i_read_en;
			r_fail_pend <= i_fail_next;
			r_wait <= 1 + $urandom % 4; // 1 to 4 busy cycles
			if (i_write_en) begin
				write_log.push_back({i_addr, i_wdata});
			end
		end else if (o_busy) begin
			if (r_wait > 1) begin
				r_wait <= r_wait - 1;
			end else begin
				o_busy <= 1'b0;
				o_fail <= r_fail_pend;
				if (r_read && !r_fail_pend) begin
					if (r_addr == sensor_chip_pkg::MPR_TOUCH_STATUS_0) begin
						o_data <= i_mask[7:0];
						r_status_0 <= i_mask[7:0];
					end else begin
						o_data <= {4'h0, i_mask[11:8]};
						pair_log.push_back({i_mask[11:8], r_status_0});
					end
				end
			end
		end
	end

endmodule

//==============================
// ads1292 bus controller
//==============================
module ads1292_model (
	input  logic                       i_CLK,
	input  logic                       i_RST,
	input  sensor_chip_pkg::ads_ctrl_t i_ctrl,
	output logic [71:0]                o_data,
	output logic                       o_data_ready
);

	sensor_pkg::payload_t data_log [$]; // channel 2 of every word sent
	logic [2:0]           ctrl_log [$]; // control codes other than dummy
	logic                 r_stream;     // read data continuous mode
	int                   r_wait;
	logic [71:0]          r_word;

	always @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			o_data <= '0;
			o_data_ready <= 1'b0;
			r_stream <= 1'b0;
			r_wait <= 0;
		end else begin
			o_data_ready <= 1'b0;
			if (i_ctrl != sensor_chip_pkg::DUMMY) begin
				ctrl_log.push_back(i_ctrl);
			end
			if (i_ctrl == sensor_chip_pkg::RDATAC) begin
				r_stream <= 1'b1;
				r_wait <= 40 + $urandom % 21;
			end else if (i_ctrl == sensor_chip_pkg::SDATAC) begin
				r_stream <= 1'b0;
			end else if (r_stream) begin
				if (r_wait <= 1) begin
					r_word = {8'($urandom), $urandom, $urandom};
					o_data <= r_word;
					o_data_ready <= 1'b1;
					data_log.push_back(r_word[23:0]);
					r_wait <= 40 + $urandom % 21; // next sample in 40 to 60 cycles
				end else begin
					r_wait <= r_wait - 1;
				end
			end
		end
	end

endmodule

// ==== sim/tb_sensor_core.sv ====
`timescale 1ns/1ps

module tb_sensor_core;

	localparam int unsigned SEED = 32'hc2f1_190b;
	localparam int MIN_ECG_GAP = 40; // shortest data ready interval of the ads model

	// test lengths in cycles
	localparam int LEN_T1 = 60;
	localparam int LEN_T2 = 600;
	localparam int LEN_T3 = 450;
	localparam int LEN_T4 = 2600;
	localparam int LEN_T5 = 500;
	localparam int LEN_T6 = 250;
	localparam int RUN_LIMIT = (LEN_T1 + LEN_T2 + LEN_T3 + LEN_T4 + LEN_T5 + LEN_T6) * 3 / 2;

	logic                       i_CLK = 1'b0;
	logic                       i_RST;
	logic                       i_uart_tx_ready;
	sensor_pkg::uart_rx_t       i_uart_rx_data;
	logic                       i_uart_rx_valid;
	logic                       i_mpr_init_set;
	logic                       i_ads_init_set;
	sensor_pkg::reg_byte_t      i_mpr_data;
	logic                       i_mpr_busy;
	logic                       i_mpr_fail;
	logic [71:0]                i_ads_data;
	logic                       i_ads_data_ready;
	sensor_pkg::uart_tx_t       o_uart_tx_data;
	logic                       o_uart_tx_valid;
	sensor_pkg::reg_byte_t      o_mpr_addr;
	sensor_pkg::reg_byte_t      o_mpr_wdata;
	logic                       o_mpr_write_en;
	logic                       o_mpr_read_en;
	logic                       o_mpr_error;
	sensor_chip_pkg::ads_ctrl_t o_ads_ctrl;
	logic                       o_run_set;
	logic                       o_core_busy;

	sensor_pkg::touch_t   mpr_mask;
	logic                 mpr_fail_next;
	logic                 bp_mode = 1'b0;     // random tx ready stalls
	logic                 ecg_skip_ok = 1'b0; // dropped ecg samples allowed
	sensor_pkg::uart_tx_t got_touch [$];
	sensor_pkg::uart_tx_t got_ecg [$];
	int                   ecg_stall [$]; // tx ready low run as each ads sample arrives
	sensor_pkg::uart_tx_t frame;
	sensor_pkg::uart_tx_t last_touch;
	sensor_pkg::touch_t   masks [5] = '{12'h0a5, 12'hf00, 12'h3c1, 12'h800, 12'hfff};
	int                   touch_pos = 0;
	int                   ecg_pos = 0;
	int                   ecg_seen = 0;
	int                   frames_sent = 0;
	int                   low_run = 0;
	int                   bp_left = 0;
	int                   cycles = 0;
	int                   errors = 0;
	int                   errors_mark = 0;
	int                   checks = 0;
	int                   tests_done = 0;
	int unsigned          seed_dummy;

	always #4 i_CLK = ~i_CLK;

	sensor_core #(
		.FIFO_DEPTH (8)
	) dut0 (
		.i_CLK            (i_CLK),
		.i_RST            (i_RST),
		.o_uart_tx_data   (o_uart_tx_data),
		.o_uart_tx_valid  (o_uart_tx_valid),
		.i_uart_tx_ready  (i_uart_tx_ready),
		.i_uart_rx_data   (i_uart_rx_data),
		.i_uart_rx_valid  (i_uart_rx_valid),
		.i_mpr_data       (i_mpr_data),
		.o_mpr_addr       (o_mpr_addr),
		.o_mpr_wdata      (o_mpr_wdata),
		.o_mpr_write_en   (o_mpr_write_en),
		.o_mpr_read_en    (o_mpr_read_en),
		.i_mpr_init_set   (i_mpr_init_set),
		.i_mpr_busy       (i_mpr_busy),
		.i_mpr_fail       (i_mpr_fail),
		.o_mpr_error      (o_mpr_error),
		.i_ads_data       (i_ads_data),
		.o_ads_ctrl       (o_ads_ctrl),
		.i_ads_init_set   (i_ads_init_set),
		.i_ads_data_ready (i_ads_data_ready),
		.o_run_set        (o_run_set),
		.o_core_busy      (o_core_busy)
	);

	mpr121_model mpr0 (
		.i_CLK       (i_CLK),
		.i_RST       (i_RST),
		.i_addr      (o_mpr_addr),
		.i_wdata     (o_mpr_wdata),
		.i_write_en  (o_mpr_write_en),
		.i_read_en   (o_mpr_read_en),
		.i_mask      (mpr_mask),
		.i_fail_next (mpr_fail_next),
		.o_data      (i_mpr_data),
		.o_busy      (i_mpr_busy),
		.o_fail      (i_mpr_fail)
	);

	ads1292_model ads0 (
		.i_CLK        (i_CLK),
		.i_RST        (i_RST),
		.i_ctrl       (o_ads_ctrl),
		.o_data       (i_ads_data),
		.o_data_ready (i_ads_data_ready)
	);

	//==============================
	// reference and checks
	//==============================
	function automatic sensor_pkg::uart_tx_t expect_frame(input sensor_pkg::sample_tag_t tag,
		input sensor_pkg::payload_t payload);
		if (tag == sensor_pkg::TAG_ECG) begin
			return {sensor_pkg::HDR_ECG, payload};
		end
		return {sensor_pkg::HDR_TOUCH, 4'h0, payload[11:0], 8'h00};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic flag_error(input string what);
		errors++;
		$display("error: %s", what);
	endtask

	task automatic end_test(input int num, input string name);
		$display("test %0d %s: %s, %0d errors", num, name,
			(errors == errors_mark) ? "ok" : "mismatch", errors - errors_mark);
		errors_mark = errors;
		tests_done++;
	endtask

	task automatic send_command(input sensor_pkg::reg_byte_t code);
		@(posedge i_CLK);
		i_uart_rx_data <= {code, 8'h00};
		i_uart_rx_valid <= 1'b1;
		@(posedge i_CLK);
		i_uart_rx_valid <= 1'b0;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge i_CLK);
	endtask

	// tx ready with long random stalls in back-pressure mode
	initial begin
		i_uart_tx_ready <= 1'b1;
		forever begin
			@(posedge i_CLK);
			if (!bp_mode) begin
				i_uart_tx_ready <= 1'b1;
			end else if (bp_left > 0) begin
				bp_left--;
			end else if (i_uart_tx_ready) begin
				i_uart_tx_ready <= 1'b0;
				bp_left = 20 + $urandom % 130;
			end else begin
				i_uart_tx_ready <= 1'b1;
				bp_left = 5 + $urandom % 40;
			end
		end
	end

	// frame monitor sorts by header byte
	always @(posedge i_CLK) begin
		if (!i_RST && o_uart_tx_valid && i_uart_tx_ready) begin
			frames_sent++;
			if (o_uart_tx_data[31:24] == sensor_pkg::HDR_ECG) begin
				got_ecg.push_back(o_uart_tx_data);
			end else if (o_uart_tx_data[31:24] == sensor_pkg::HDR_TOUCH) begin
				got_touch.push_back(o_uart_tx_data);
			end else begin
				flag_error("frame with an unknown header byte");
			end
		end
		if (i_ads_data_ready) begin
			ecg_stall.push_back(low_run); // stall up to the cycle before this sample
		end
		if (!i_uart_tx_ready) begin
			low_run++;
		end else begin
			low_run = 0;
		end
	end

	// compare in order against what the models handed out
	always @(negedge i_CLK) begin
		while (got_touch.size() > 0) begin
			frame = got_touch.pop_front();
			if (touch_pos < mpr0.pair_log.size()) begin
				check_value("o_uart_tx_data touch", frame,
					expect_frame(sensor_pkg::TAG_TOUCH, {12'h000, mpr0.pair_log[touch_pos]}));
			end else begin
				flag_error("touch frame sent without a completed status read pair");
			end
			touch_pos++;
			last_touch = frame;
		end
		while (got_ecg.size() > 0) begin
			frame = got_ecg.pop_front();
			if (ecg_skip_ok) begin
				while (ecg_pos < ads0.data_log.size() &&
					expect_frame(sensor_pkg::TAG_ECG, ads0.data_log[ecg_pos]) != frame) begin
					// a few cycles of pipeline between the stall and the lost sample
					if (ecg_pos < ecg_stall.size() && ecg_stall[ecg_pos] < MIN_ECG_GAP - 4) begin
						flag_error("ecg sample dropped without a long tx ready stall");
					end
					ecg_pos++;
				end
			end
			if (ecg_pos < ads0.data_log.size()) begin
				check_value("o_uart_tx_data ecg", frame,
					expect_frame(sensor_pkg::TAG_ECG, ads0.data_log[ecg_pos]));
			end else begin
				flag_error("ecg frame not found in the model data log");
			end
			ecg_pos++;
			ecg_seen++;
		end
	end

	// watchdog
	initial begin
		while (cycles < RUN_LIMIT) begin
			@(posedge i_CLK);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", RUN_LIMIT);
		$display("Simulation FAILED");
		$finish;
	end

	//==============================
	// test sequence
	//==============================
	initial begin
		int mark;
		int sent_before;

		seed_dummy = $urandom(SEED);
		i_RST <= 1'b1;
		i_uart_rx_data <= '0;
		i_uart_rx_valid <= 1'b0;
		i_mpr_init_set <= 1'b0;
		i_ads_init_set <= 1'b0;
		mpr_mask <= 12'h123;
		mpr_fail_next <= 1'b0;
		wait_cycles(4);
		i_RST <= 1'b0;

		// test 1 with reset values and a command before init
		@(negedge i_CLK);
		check_value("o_uart_tx_valid", o_uart_tx_valid, 0);
		check_value("touch_s.valid", dut0.touch_s.valid, 0);
		check_value("ecg_s.valid", dut0.ecg_s.valid, 0);
		check_value("o_mpr_write_en", o_mpr_write_en, 0);
		check_value("o_mpr_read_en", o_mpr_read_en, 0);
		check_value("o_mpr_error", o_mpr_error, 0);
		check_value("o_run_set", o_run_set, 0);
		check_value("o_core_busy", o_core_busy, 0);
		check_value("o_ads_ctrl", o_ads_ctrl, sensor_chip_pkg::DUMMY);
		send_command(sensor_pkg::CMD_RUN);
		wait_cycles(30);
		check_value("mpr write count", mpr0.write_log.size(), 0);
		check_value("ads control count", ads0.ctrl_log.size(), 0);
		end_test(1, "reset and early command");

		// test 2 where touch frames follow the mask
		@(posedge i_CLK);
		i_mpr_init_set <= 1'b1;
		i_ads_init_set <= 1'b1;
		wait_cycles(2);
		send_command(sensor_pkg::CMD_RUN);
		while (!o_run_set) @(posedge i_CLK);
		check_value("o_core_busy", o_core_busy, 1);
		check_value("mpr write count", mpr0.write_log.size(), 1);
		check_value("mpr run write", mpr0.write_log[0],
			{sensor_chip_pkg::MPR_ELE_CONFIG, sensor_chip_pkg::MPR_ELE_RUN});
		check_value("o_ads_ctrl first code", ads0.ctrl_log[0], sensor_chip_pkg::RDATAC);
		foreach (masks[i]) begin
			@(posedge i_CLK);
			mpr_mask <= masks[i];
			mark = touch_pos + 4; // older samples still in flight
			while (touch_pos < mark) @(posedge i_CLK);
			check_value("touch frame mask", last_touch,
				expect_frame(sensor_pkg::TAG_TOUCH, {12'h000, masks[i]}));
		end
		end_test(2, "run and touch frames");

		// test 3 with an ecg stream free of stalls
		mark = ecg_seen + 5;
		while (ecg_seen < mark) @(posedge i_CLK);
		if (ads0.data_log.size() - ecg_pos > 1) begin
			flag_error("ecg samples missing from the transmit stream");
		end
		end_test(3, "ecg frames in order");

		// test 4 under tx back-pressure
		ecg_skip_ok = 1'b1;
		bp_mode <= 1'b1;
		wait_cycles(2000);
		bp_mode <= 1'b0;
		mark = ecg_seen + 2;
		while (ecg_seen < mark) @(posedge i_CLK);
		ecg_skip_ok = 1'b0;
		end_test(4, "tx back-pressure");

		// test 5 where the stream drains after stop and stays quiet
		send_command(sensor_pkg::CMD_STOP);
		while (o_run_set || o_core_busy) @(posedge i_CLK);
		while (mpr0.write_log.size() < 2) @(posedge i_CLK);
		wait_cycles(100);
		@(negedge i_CLK);
		sent_before = frames_sent;
		wait_cycles(200);
		@(negedge i_CLK);
		check_value("frames after drain", frames_sent, sent_before);
		check_value("mpr stop write", mpr0.write_log[1],
			{sensor_chip_pkg::MPR_ELE_CONFIG, sensor_chip_pkg::MPR_ELE_STOP});
		check_value("o_ads_ctrl last code", ads0.ctrl_log[ads0.ctrl_log.size() - 1],
			sensor_chip_pkg::SDATAC);
		check_value("touch frame count", touch_pos, mpr0.pair_log.size());
		if (ads0.data_log.size() - ecg_pos > 1) begin
			flag_error("ecg samples never sent after stop");
		end
		ecg_pos = ads0.data_log.size(); // a sample during sdatac is lost
		end_test(5, "stop and drain");

		// test 6 where a failed access latches the error
		@(posedge i_CLK);
		mpr_fail_next <= 1'b1;
		send_command(sensor_pkg::CMD_RUN);
		while (!o_mpr_error) @(posedge i_CLK);
		mpr_fail_next <= 1'b0;
		repeat (100) begin
			@(negedge i_CLK);
			check_value("o_mpr_error", o_mpr_error, 1);
		end
		@(posedge i_CLK);
		i_RST <= 1'b1;
		wait_cycles(4);
		i_RST <= 1'b0;
		@(negedge i_CLK);
		check_value("o_mpr_error after reset", o_mpr_error, 0);
		check_value("o_run_set after reset", o_run_set, 0);
		end_test(6, "bus failure");

		$display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
source/sensor_pkg.sv
source/sensor_chip_pkg.sv
source/sample_if.sv
source/run_control.sv
source/touch_poller.sv
source/ecg_capture.sv
source/frame_fifo.sv
source/uart_framer.sv
source/sensor_core.sv
sim/chip_models.sv
sim/tb_sensor_core.sv
